// File: common/scale_pkg.sv
// Stream scaler shared definitions
`default_nettype none

package scale_pkg;

  // One unsigned sample as it travels from input to output
  typedef logic [15:0] sample_t;

  // Multiplier applied to every sample
  typedef logic [7:0] gain_t;

  // Added after the multiplication
  typedef logic [15:0] offset_t;

  // Configuration address and write data
  typedef logic [0:0] cfg_addr_t;
  typedef logic [15:0] cfg_data_t;

  // Occupancy and drop counters, both wrap on overflow
  typedef logic [15:0] count_t;

  // Register map of the configuration block
  localparam cfg_addr_t CfgAddrGain = 1'b0;
  localparam cfg_addr_t CfgAddrOffset = 1'b1;

  // Identity transform after reset
  localparam gain_t GainReset = 8'd1;
  localparam offset_t OffsetReset = 16'd0;

  // Both spill slices of the top level use this setting
  localparam bit SpillBypass = 1'b0;

  // Results above this limit are clamped
  localparam sample_t SampleMax = 16'hFFFF;

endpackage

`default_nettype wire

// File: spill/spill_register_flushable.sv
// Flushable spill register
`timescale 1ns/100ps
`default_nettype none

module spill_register_flushable import scale_pkg::*; #(
  // With Bypass set the slice degenerates into plain wires
  parameter bit Bypass = 1'b0
) (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire logic    valid_i,
  input  wire logic    flush_i,
  output logic         ready_o,
  input  wire sample_t data_i,
  output logic         valid_o,
  input  wire logic    ready_i,
  output sample_t      data_o
);

  if (Bypass) begin : gen_bypass
    // No storage, so both handshakes are joined combinationally
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    sample_t a_data_q;
    sample_t b_data_q;
    logic    a_full_q;
    logic    b_full_q;
    logic    a_fill;
    logic    a_drain;
    logic    b_fill;
    logic    b_drain;

    // Entry A takes every accepted sample, a flush never loads it
    assign a_fill = valid_i && ready_o && !flush_i;

    // A empties whenever B has room, or on a flush
    assign a_drain = (a_full_q && !b_full_q) || flush_i;

    // A sample leaving A goes into B only if downstream stalls
    assign b_fill = a_drain && !ready_i && !flush_i;

    // B empties on a downstream handshake or on a flush
    assign b_drain = (b_full_q && ready_i) || flush_i;

    // Room exists as long as one of the two entries is free
    assign ready_o = !a_full_q || !b_full_q;

    // Output is valid as soon as either entry holds a sample
    assign valid_o = a_full_q || b_full_q;

    // B holds the older sample, so it goes out first
    assign data_o = b_full_q ? b_data_q : a_data_q;

    // Payload of entry A
    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
    end

    // Payload of entry B, always taken from A
    always_ff @(posedge clk_i) begin
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Full flag of A; a fill in the same cycle as a drain keeps it set
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        a_full_q <= 1'b0;
      end else if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
    end

    // Full flag of B
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        b_full_q <= 1'b0;
      end else if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/scale_cfg_regs.sv
// Scaler configuration registers
`timescale 1ns/100ps
`default_nettype none

module scale_cfg_regs import scale_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      cfg_we_i,
  input  wire cfg_addr_t cfg_addr_i,
  input  wire cfg_data_t cfg_wdata_i,
  output gain_t          gain_o,
  output offset_t        offset_o
);

  gain_t   gain_q;
  offset_t offset_q;
  logic    gain_we;
  logic    offset_we;

  // Address decode of the write strobe
  assign gain_we   = cfg_we_i && (cfg_addr_i == CfgAddrGain);
  assign offset_we = cfg_we_i && (cfg_addr_i == CfgAddrOffset);

  // Gain register, only the low byte of the write data is kept
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gain_q <= GainReset;
    end else if (gain_we) begin
      gain_q <= cfg_wdata_i[$bits(gain_t)-1:0];
    end
  end

  // Offset register uses the full write data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= OffsetReset;
    end else if (offset_we) begin
      offset_q <= cfg_wdata_i;
    end
  end

  // A sample accepted on the write edge still sees the old value here,
  // since the register output only changes after that edge
  assign gain_o   = gain_q;
  assign offset_o = offset_q;

endmodule

`default_nettype wire

// File: logic/affine_sat.sv
// Saturating gain and offset transform
`timescale 1ns/100ps
`default_nettype none

module affine_sat import scale_pkg::*; (
  input  wire sample_t data_i,
  input  wire gain_t   gain_i,
  input  wire offset_t offset_i,
  output sample_t      data_o
);

  // Product keeps every bit of sample times gain
  logic [$bits(sample_t)+$bits(gain_t)-1:0] product;

  // One extra bit holds the carry of the offset addition
  logic [$bits(sample_t)+$bits(gain_t):0] sum;

  logic overflow;

  // Both operands are unsigned and widen to the product width
  assign product = data_i * gain_i;

  // Offset is zero extended before the addition
  assign sum = product + offset_i;

  // Anything above the largest sample value is out of range
  assign overflow = (sum > SampleMax);

  // Clamp, otherwise the low bits are the exact result
  assign data_o = overflow ? SampleMax : sum[$bits(sample_t)-1:0];

endmodule

`default_nettype wire

// File: logic/stream_occupancy.sv
// In-flight and drop counters
`timescale 1ns/100ps
`default_nettype none

module stream_occupancy import scale_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic in_fire_i,
  input  wire logic out_fire_i,
  input  wire logic flush_i,
  output count_t    inflight_o,
  output count_t    dropped_o
);

  count_t inflight_q;
  count_t dropped_q;
  count_t in_inc;
  count_t out_dec;
  count_t flushed;

  // Handshakes widened to counter width
  assign in_inc  = count_t'(in_fire_i);
  assign out_dec = count_t'(out_fire_i);

  // A delivery in the flush cycle still counts as delivered,
  // so it is not part of what the flush throws away
  assign flushed = inflight_q - out_dec;

  // Occupancy goes up on input and down on output, a flush clears it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
    end else if (flush_i) begin
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_q + in_inc - out_dec;
    end
  end

  // Running total of discarded samples, wraps on overflow
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dropped_q <= '0;
    end else if (flush_i) begin
      dropped_q <= dropped_q + flushed;
    end
  end

  assign inflight_o = inflight_q;
  assign dropped_o  = dropped_q;

endmodule

`default_nettype wire

// File: logic/scale_stream_top.sv
// Flushable stream scaler top level
`timescale 1ns/100ps
`default_nettype none

module scale_stream_top import scale_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      cfg_we_i,
  input  wire cfg_addr_t cfg_addr_i,
  input  wire cfg_data_t cfg_wdata_i,
  input  wire logic      valid_i,
  output logic           ready_o,
  input  wire sample_t   data_i,
  input  wire logic      flush_i,
  output logic           valid_o,
  input  wire logic      ready_i,
  output sample_t        data_o,
  output count_t         inflight_o,
  output count_t         dropped_o
);

  gain_t   gain;
  offset_t offset;
  sample_t scaled;

  // Handshake between the two slices
  logic    mid_valid;
  logic    mid_ready;
  sample_t mid_data;

  // Transfers on the outer handshakes feed the tracker
  logic in_fire;
  logic out_fire;

  assign in_fire  = valid_i && ready_o;
  assign out_fire = valid_o && ready_i;

  scale_cfg_regs u_cfg_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_we_i   (cfg_we_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i),
    .gain_o     (gain),
    .offset_o   (offset)
  );

  // Transform sits before the first slice, so it uses the
  // configuration that is current at the acceptance edge
  affine_sat u_affine_sat (
    .data_i  (data_i),
    .gain_i  (gain),
    .offset_i(offset),
    .data_o  (scaled)
  );

  spill_register_flushable #(.Bypass(SpillBypass)) slice_in (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(valid_i),
    .flush_i(flush_i),
    .ready_o(ready_o),
    .data_i (scaled),
    .valid_o(mid_valid),
    .ready_i(mid_ready),
    .data_o (mid_data)
  );

  spill_register_flushable #(.Bypass(SpillBypass)) slice_out (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(mid_valid),
    .flush_i(flush_i),
    .ready_o(mid_ready),
    .data_i (mid_data),
    .valid_o(valid_o),
    .ready_i(ready_i),
    .data_o (data_o)
  );

  stream_occupancy u_occupancy (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_fire_i (in_fire),
    .out_fire_i(out_fire),
    .flush_i   (flush_i),
    .inflight_o(inflight_o),
    .dropped_o (dropped_o)
  );

endmodule

`default_nettype wire

// File: tb/scale_stream_chk.sv
// Stream scaler protocol checks
`timescale 1ns/100ps
`default_nettype none

module scale_stream_chk import scale_pkg::*; (
  input wire logic    clk_i,
  input wire logic    rst_ni,
  input wire logic    valid_i,
  input wire logic    flush_i,
  input wire logic    valid_o,
  input wire logic    ready_i,
  input wire sample_t data_o
);

  // The slices do not handle a sample that arrives together with a flush
  flush_excludes_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(flush_i && valid_i)
  ) else $error("flush_i and valid_i are high in the same cycle");

  // A stalled output keeps its valid until taken or flushed
  valid_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (valid_o && !ready_i && !flush_i) |=> valid_o
  ) else $error("valid_o dropped while the output was stalled");

  // Payload of a stalled output must not move either
  data_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (valid_o && !ready_i && !flush_i) |=> $stable(data_o)
  ) else $error("data_o changed while the output was stalled");

endmodule

bind scale_stream_top scale_stream_chk u_chk (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .valid_i(valid_i),
  .flush_i(flush_i),
  .valid_o(valid_o),
  .ready_i(ready_i),
  .data_o (data_o)
);

`default_nettype wire

// File: tb/tb_scale_stream.sv
// Stream scaler testbench
`timescale 1ns/100ps
`default_nettype none

module tb_scale_stream import scale_pkg::*; ();

  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 8;
  localparam int StimCycles  = 3000;
  localparam int DrainCycles = 100;
  localparam int BurstCycles = 12;
  localparam int Seed        = 8586;
  // Latency probe takes three cycles on top of the back-pressure burst
  localparam int DirectedCycles = BurstCycles + 3;
  localparam int CycleLimit = ResetCycles + StimCycles + DirectedCycles + DrainCycles;

  logic      clk_i;
  logic      rst_ni;
  logic      cfg_we_i;
  cfg_addr_t cfg_addr_i;
  cfg_data_t cfg_wdata_i;
  logic      valid_i;
  logic      ready_o;
  sample_t   data_i;
  logic      flush_i;
  logic      valid_o;
  logic      ready_i;
  sample_t   data_o;
  count_t    inflight_o;
  count_t    dropped_o;

  // Reference model state
  sample_t     exp_q[$];
  gain_t       gain_model;
  offset_t     offset_model;
  count_t      drop_model;
  logic        flush_seen;
  logic        hold_pending;
  sample_t     hold_data;
  int          error_count;
  int          delivered_count;
  int          cycle_count = 0;
  int unsigned seed_init;

  scale_stream_top DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_we_i   (cfg_we_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i),
    .valid_i    (valid_i),
    .ready_o    (ready_o),
    .data_i     (data_i),
    .flush_i    (flush_i),
    .valid_o    (valid_o),
    .ready_i    (ready_i),
    .data_o     (data_o),
    .inflight_o (inflight_o),
    .dropped_o  (dropped_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Hard limit on the run length in case the pipeline never drains
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CycleLimit) begin
      $display("Timeout after %0d cycles, the run did not finish in time", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  // Sample times gain plus offset, clamped at the largest sample value
  function automatic sample_t expected_sample(sample_t data, gain_t gain, offset_t offset);
    int unsigned full;
    full = 32'(data) * 32'(gain) + 32'(offset);
    if (full > 32'(SampleMax)) begin
      return SampleMax;
    end
    return sample_t'(full);
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic report_fault(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic idle_inputs();
    valid_i     = 1'b0;
    data_i      = '0;
    flush_i     = 1'b0;
    ready_i     = 1'b1;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = CfgAddrGain;
    cfg_wdata_i = '0;
  endtask

  // Flush only in idle input cycles, no configuration writes early on
  task automatic drive_random(input int cycle);
    valid_i = ($urandom % 3) != 0;
    data_i = (($urandom % 2) != 0) ? sample_t'($urandom) : sample_t'($urandom % 256);
    ready_i = ($urandom % 4) != 0;
    flush_i = !valid_i && (($urandom % 40) == 0);
    cfg_we_i = (cycle > 50) && (($urandom % 20) == 0);
    cfg_addr_i = cfg_addr_t'($urandom % 2);
    // Small offsets keep a share of the results below the clamp
    if (cfg_addr_i == CfgAddrOffset) begin
      cfg_wdata_i = cfg_data_t'($urandom % 4096);
    end else begin
      cfg_wdata_i = cfg_data_t'($urandom);
    end
  endtask

  // Called shortly before the rising edge, while all signals are settled
  task automatic sample_cycle();
    logic    in_fire;
    logic    out_fire;
    sample_t head;
    in_fire  = valid_i && ready_o;
    out_fire = valid_o && ready_i;
    assert (inflight_o == count_t'(exp_q.size())) else
      report_mismatch($sformatf("inflight_o is %0d, expected %0d", inflight_o, exp_q.size()));
    assert (dropped_o == drop_model) else
      report_mismatch($sformatf("dropped_o is %0d, expected %0d", dropped_o, drop_model));
    assert (!valid_o || exp_q.size() != 0) else
      report_fault("valid_o is high although no sample is in flight");
    if (flush_seen) begin
      assert (!valid_o) else report_mismatch("valid_o is high right after a flush");
    end
    if (hold_pending) begin
      assert (valid_o && data_o == hold_data) else
        report_mismatch($sformatf("stalled output changed to %h/%b", data_o, valid_o));
    end
    // Input stalls only when slice_in is full, which needs three or four samples
    if (exp_q.size() < 3) begin
      assert (ready_o) else report_mismatch("ready_o low with fewer than three in flight");
    end
    if (exp_q.size() == 4) begin
      assert (!ready_o) else report_mismatch("ready_o high with four in flight");
    end
    if (out_fire) begin
      assert (exp_q.size() != 0) else report_fault("DUT delivered a sample that was never sent");
      if (exp_q.size() != 0) begin
        head = exp_q.pop_front();
        delivered_count++;
        assert (data_o == head) else
          report_mismatch($sformatf("data_o is %h, expected %h", data_o, head));
      end
    end
    // Sample on the write edge still sees the old configuration
    if (in_fire) begin
      exp_q.push_back(expected_sample(data_i, gain_model, offset_model));
    end
    // Delivery of this cycle was already popped and counts as delivered
    if (flush_i) begin
      drop_model = drop_model + count_t'(exp_q.size());
      exp_q.delete();
    end
    if (cfg_we_i && cfg_addr_i == CfgAddrGain) begin
      gain_model = gain_t'(cfg_wdata_i);
    end
    if (cfg_we_i && cfg_addr_i == CfgAddrOffset) begin
      offset_model = offset_t'(cfg_wdata_i);
    end
    flush_seen   = flush_i;
    hold_pending = valid_o && !ready_i && !flush_i;
    hold_data    = data_o;
  endtask

  // Inputs are set at the falling edge before this is called
  task automatic step_cycle();
    #(ClkPeriod / 2 - 1);
    sample_cycle();
    @(negedge clk_i);
  endtask

  task automatic drain_pipeline();
    idle_inputs();
    while (exp_q.size() != 0 || valid_o) begin
      step_cycle();
    end
  endtask

  task automatic check_reset_state();
    assert (!valid_o) else report_mismatch("valid_o is high after reset");
    assert (ready_o) else report_mismatch("ready_o is low after reset");
    assert (inflight_o == '0) else report_mismatch("inflight_o is not 0 after reset");
    assert (dropped_o == '0) else report_mismatch("dropped_o is not 0 after reset");
  endtask

  // One sample into an empty pipeline appears two edges later
  task automatic check_latency();
    valid_i = 1'b1;
    data_i  = sample_t'($urandom);
    step_cycle();
    valid_i = 1'b0;
    assert (!valid_o) else report_mismatch("valid_o high one edge after acceptance");
    step_cycle();
    assert (valid_o) else report_mismatch("valid_o low two edges after acceptance");
    step_cycle();
  endtask

  // Output held off, so the pipeline must take exactly four samples
  task automatic check_backpressure();
    ready_i = 1'b0;
    for (int i = 0; i < BurstCycles; i++) begin
      valid_i = 1'b1;
      data_i  = sample_t'($urandom);
      assert (ready_o == (exp_q.size() < 4)) else
        report_mismatch($sformatf("ready_o is %b with %0d in flight", ready_o, exp_q.size()));
      step_cycle();
    end
    idle_inputs();
  endtask

  initial begin
    seed_init       = $urandom(Seed);
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    gain_model      = GainReset;
    offset_model    = OffsetReset;
    drop_model      = '0;
    flush_seen      = 1'b0;
    hold_pending    = 1'b0;
    hold_data       = '0;
    error_count     = 0;
    delivered_count = 0;
    idle_inputs();
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_reset_state();
    for (int i = 0; i < StimCycles; i++) begin
      drive_random(i);
      step_cycle();
    end
    drain_pipeline();
    check_latency();
    check_backpressure();
    drain_pipeline();
    $display("Delivered %0d samples, dropped %0d, errors %0d",
             delivered_count, drop_model, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
common/scale_pkg.sv
spill/spill_register_flushable.sv
logic/scale_cfg_regs.sv
logic/affine_sat.sv
logic/stream_occupancy.sv
logic/scale_stream_top.sv
tb/scale_stream_chk.sv
tb/tb_scale_stream.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the stream scaler testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_scale_stream
BUILD_DIR=obj_dir
LOG_FILE=sim.log

# Assertions are compiled in so both the testbench checks and the bound checker run
verilator --binary --assert -Wno-fatal \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" \
  -f sources.f

# A simulator that stops on an assertion exits non-zero and ends the script here
"./$BUILD_DIR/V$TOP" 2>&1 | tee "$LOG_FILE"

if grep -q "Simulation failed" "$LOG_FILE"; then
  echo "Result: FAIL"
  exit 1
fi

echo "Result: PASS"
exit 0
